//--- design/rvv_arch_pkg.sv
// Vector architecture constants for the dispatch backend.
// VLEN is fixed at 128 bits and element widths stop at 32 bits.
// LMUL is at most 8, so a register group holds up to 8 uops.

package rvv_arch_pkg;

    localparam int unsigned VLEN  = 128;        // bits per vector register
    localparam int unsigned VLENB = VLEN / 8;   // bytes per vector register

    // byte position inside one vector register
    typedef logic [$clog2(VLENB)-1:0] vlenb_idx_t;

    // vl spans 0..VLEN inclusive, so one extra bit
    typedef logic [$clog2(VLEN):0] vl_t;

    typedef logic [$clog2(VLEN)-1:0] vstart_t;  // element index, 0..VLEN-1

    typedef logic [2:0] uop_idx_t;   // uop number within a register group

    typedef logic [VLEN-1:0] v0_t;   // whole mask register

    // element width; the value equals log2 of the width in bytes
    // encoding 2'b11 is reserved and never sent to dispatch
    typedef enum logic [1:0] {
        EEW8  = 2'd0,
        EEW16 = 2'd1,
        EEW32 = 2'd2
    } eew_e;

    // label for each byte of an operand
    typedef enum logic [1:0] {
        NOT_CHANGE    = 2'd0,   // prestart, element below vstart
        BODY_INACTIVE = 2'd1,   // masked off by v0
        BODY_ACTIVE   = 2'd2,
        TAIL          = 2'd3    // element at or above vl
    } byte_type_e;

endpackage

//--- design/rvv_dispatch_pkg.sv
// Uop payload types for the dispatch stage.
// uop_id is only a tag that follows the uop through the pipe.

package rvv_dispatch_pkg;

    // uop info as it arrives from decode
    typedef struct packed {
        logic [7:0]             uop_id;
        rvv_arch_pkg::uop_idx_t uop_index;
        logic                   vm;         // 1 means unmasked
        rvv_arch_pkg::vl_t      vl;
        rvv_arch_pkg::vstart_t  vstart;
        rvv_arch_pkg::eew_e     vs1_eew;
        rvv_arch_pkg::eew_e     vs2_eew;
        rvv_arch_pkg::eew_e     vd_eew;
    } uop_info_t;

    // one label per byte of a vector register
    typedef rvv_arch_pkg::byte_type_e [rvv_arch_pkg::VLENB-1:0] byte_type_vec_t;

    typedef struct packed {
        byte_type_vec_t vs1;
        byte_type_vec_t vs2;
        byte_type_vec_t vd;
    } opr_byte_type_t;

    // what leaves dispatch
    typedef struct packed {
        uop_info_t      uop_info;
        opr_byte_type_t byte_type;
    } dispatch_uop_t;

endpackage

//--- design/rvv_uop_queue.sv
// Synchronous uop FIFO between the input port and dispatch.
// Head is read combinationally; push and pop may share a cycle.
// DEPTH must be at least 2.
`timescale 1ns/1ps

module rvv_uop_queue #(
    parameter int unsigned DEPTH = 4
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        in_valid,
    output logic                        in_ready,
    input  rvv_dispatch_pkg::uop_info_t in_uop,
    output logic                        head_valid,
    input  logic                        head_ready,
    output rvv_dispatch_pkg::uop_info_t head_uop
);

    localparam int unsigned PTR_W = $clog2(DEPTH);
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;

    rvv_dispatch_pkg::uop_info_t mem [DEPTH];

    ptr_t wr_ptr;
    ptr_t rd_ptr;
    cnt_t count;
    logic push;
    logic pop;

    // wrap by hand so DEPTH need not be a power of two
    function automatic ptr_t next_ptr(input ptr_t ptr);
        return (ptr == ptr_t'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign in_ready   = (count != cnt_t'(DEPTH));
    assign head_valid = (count != '0);
    assign head_uop   = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = head_valid && head_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= next_ptr(wr_ptr);
            if (pop)  rd_ptr <= next_ptr(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // idle or push+pop
            endcase
        end
    end

    // storage only, no reset
    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= in_uop;
    end

    a_count_max: assert property (
        @(posedge clk) disable iff (!rst_n)
        count <= cnt_t'(DEPTH)
    ) else $error("uop queue count above DEPTH");

    // a stalled head must stay put until dispatch takes it
    a_head_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (head_valid && !head_ready) |=> (head_valid && $stable(head_uop))
    ) else $error("uop queue head changed while stalled");

endmodule

//--- design/rvv_opr_byte_type.sv
// Per-byte labels for vs1, vs2 and vd of one uop, purely combinational.
// One tail rule for all operands: element index >= vl is tail.
`timescale 1ns/1ps

module rvv_opr_byte_type (
    input  rvv_dispatch_pkg::uop_info_t      uop_info,
    input  rvv_arch_pkg::v0_t                v0_enable,
    output rvv_dispatch_pkg::opr_byte_type_t operand_byte_type
);

    localparam int unsigned BYTE_IDX_W = $bits(rvv_arch_pkg::vlenb_idx_t);

    // labels all bytes of one operand for the given element width
    function automatic rvv_dispatch_pkg::byte_type_vec_t label_bytes(
        input rvv_dispatch_pkg::uop_info_t info,
        input rvv_arch_pkg::eew_e          eew,
        input rvv_arch_pkg::v0_t           v0
    );
        logic [1:0]                      shift;
        rvv_arch_pkg::vstart_t           start;
        rvv_arch_pkg::vstart_t           ele_idx;
        rvv_arch_pkg::vlenb_idx_t        b;
        rvv_dispatch_pkg::byte_type_vec_t types;

        case (eew)
            rvv_arch_pkg::EEW8:  shift = 2'd0;
            rvv_arch_pkg::EEW16: shift = 2'd1;
            rvv_arch_pkg::EEW32: shift = 2'd2;
            default:             shift = 2'd0;  // reserved, caught by assertion
        endcase

        // first element of this uop: uop_index * (16 >> shift)
        start = rvv_arch_pkg::vstart_t'(info.uop_index) << (BYTE_IDX_W - shift);

        for (int i = 0; i < rvv_arch_pkg::VLENB; i++) begin
            b       = rvv_arch_pkg::vlenb_idx_t'(i);
            ele_idx = start + rvv_arch_pkg::vstart_t'(b >> shift);

            if ({1'b0, ele_idx} >= info.vl) begin
                types[i] = rvv_arch_pkg::TAIL;
            end else if (ele_idx < info.vstart) begin
                types[i] = rvv_arch_pkg::NOT_CHANGE;     // prestart
            end else if (info.vm || v0[ele_idx]) begin
                types[i] = rvv_arch_pkg::BODY_ACTIVE;
            end else begin
                types[i] = rvv_arch_pkg::BODY_INACTIVE;
            end
        end

        return types;
    endfunction

    // each operand labeled on its own width
    always_comb begin
        operand_byte_type.vs1 = label_bytes(uop_info, uop_info.vs1_eew, v0_enable);
        operand_byte_type.vs2 = label_bytes(uop_info, uop_info.vs2_eew, v0_enable);
        operand_byte_type.vd  = label_bytes(uop_info, uop_info.vd_eew,  v0_enable);
    end

endmodule

//--- design/rvv_dispatch_stage.sv
// Dispatch stage: v0 copy, byte labeling and one registered output slot.
// A v0 write lands at its edge; a uop loaded on that same edge sees old v0.
`timescale 1ns/1ps

module rvv_dispatch_stage (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            head_valid,
    output logic                            head_ready,
    input  rvv_dispatch_pkg::uop_info_t     head_uop,
    input  logic                            v0_wr_valid,
    input  rvv_arch_pkg::v0_t               v0_wr_data,
    output logic                            out_valid,
    input  logic                            out_ready,
    output rvv_dispatch_pkg::dispatch_uop_t out_uop
);

    rvv_arch_pkg::v0_t                v0_q;
    rvv_dispatch_pkg::opr_byte_type_t head_byte_type;
    rvv_dispatch_pkg::dispatch_uop_t  out_q;
    logic                             out_valid_q;
    logic                             load;

    // slot free, or being drained this cycle
    assign head_ready = !out_valid_q || out_ready;
    assign load       = head_valid && head_ready;

    assign out_valid = out_valid_q;
    assign out_uop   = out_q;

    // mask register always accepts a write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            v0_q <= '0;
        end else if (v0_wr_valid) begin
            v0_q <= v0_wr_data;
        end
    end

    rvv_opr_byte_type i_opr_byte_type (
        .uop_info          (head_uop),
        .v0_enable         (v0_q),
        .operand_byte_type (head_byte_type)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid_q <= 1'b0;
        end else if (head_ready) begin
            out_valid_q <= head_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_q.uop_info  <= head_uop;
            out_q.byte_type <= head_byte_type;  // labels frozen with the uop
        end
    end

    a_out_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_uop))
    ) else $error("dispatch output changed while stalled");

    // the labeler decodes only the three legal widths
    a_eew_legal: assert property (
        @(posedge clk) disable iff (!rst_n)
        head_valid |-> (head_uop.vs1_eew inside {rvv_arch_pkg::EEW8, rvv_arch_pkg::EEW16,
                                                 rvv_arch_pkg::EEW32})
                    && (head_uop.vs2_eew inside {rvv_arch_pkg::EEW8, rvv_arch_pkg::EEW16,
                                                 rvv_arch_pkg::EEW32})
                    && (head_uop.vd_eew  inside {rvv_arch_pkg::EEW8, rvv_arch_pkg::EEW16,
                                                 rvv_arch_pkg::EEW32})
    ) else $error("reserved element width at dispatch");

endmodule

//--- design/rvv_dispatch_top.sv
// Dispatch top: uop queue feeding the dispatch stage.
// Input to out_valid is 2 cycles minimum, longer under back-pressure.
`timescale 1ns/1ps

module rvv_dispatch_top #(
    parameter int unsigned QUEUE_DEPTH = 4
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            in_valid,
    output logic                            in_ready,
    input  rvv_dispatch_pkg::uop_info_t     in_uop,
    input  logic                            v0_wr_valid,
    input  rvv_arch_pkg::v0_t               v0_wr_data,
    output logic                            out_valid,
    input  logic                            out_ready,
    output rvv_dispatch_pkg::dispatch_uop_t out_uop
);

    logic                        head_valid;
    logic                        head_ready;
    rvv_dispatch_pkg::uop_info_t head_uop;

    rvv_uop_queue #(
        .DEPTH (QUEUE_DEPTH)
    ) i_uop_queue (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_uop     (in_uop),
        .head_valid (head_valid),
        .head_ready (head_ready),
        .head_uop   (head_uop)
    );

    rvv_dispatch_stage i_dispatch_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .head_valid  (head_valid),
        .head_ready  (head_ready),
        .head_uop    (head_uop),
        .v0_wr_valid (v0_wr_valid),
        .v0_wr_data  (v0_wr_data),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_uop     (out_uop)
    );

endmodule

//--- test/tb_rvv_dispatch_table.svh
// Directed entries for the dispatch testbench, one uop per entry.
// columns: uop_index, vm, vl, vstart, vs1/vs2/vd eew (0=8b 1=16b 2=32b), v0, out_ready pattern

function automatic void load_table();
    // vm set, tail against body-active
    table_q.push_back('{0, 1, 0,   0, 0, 0, 0, 128'h0, 8'hff});
    table_q.push_back('{0, 1, 5,   0, 0, 1, 2, 128'h0, 8'hff});
    table_q.push_back('{1, 1, 5,   0, 0, 1, 2, 128'h0, 8'h0f});
    table_q.push_back('{7, 1, 128, 0, 0, 0, 0, 128'h0, 8'hff});
    table_q.push_back('{3, 1, 128, 0, 1, 1, 1, 128'h0, 8'h55});
    table_q.push_back('{7, 1, 128, 0, 2, 2, 2, 128'h0, 8'hff});
    table_q.push_back('{2, 1, 40,  0, 0, 1, 2, 128'h0, 8'h33});
    table_q.push_back('{4, 1, 70,  0, 1, 2, 0, 128'h0, 8'hff});
    table_q.push_back('{5, 1, 100, 0, 2, 0, 1, 128'h0, 8'h81});
    table_q.push_back('{6, 1, 128, 0, 0, 2, 1, 128'h0, 8'hff});
    // vm clear, mask from v0
    table_q.push_back('{0, 0, 128, 0, 0, 0, 0, {8{16'haaaa}}, 8'hff});
    table_q.push_back('{1, 0, 128, 0, 0, 1, 2,
                        128'h0123456789abcdeffedcba9876543210, 8'h33});
    table_q.push_back('{7, 0, 128, 0, 0, 0, 0, {16{8'hf0}}, 8'hff});
    table_q.push_back('{2, 0, 50,  0, 1, 1, 2, {4{32'h8421c3e7}}, 8'h69});
    table_q.push_back('{0, 0, 16,  0, 2, 2, 2, 128'hff, 8'h0f});
    // prestart, tail still wins above vl
    table_q.push_back('{0, 1, 16,  5,  0, 0, 0, 128'h0, 8'hff});
    table_q.push_back('{0, 0, 10,  12, 0, 1, 2, {8{16'h5555}}, 8'hff});
    table_q.push_back('{1, 0, 64,  20, 0, 1, 2, {4{32'hffff0000}}, 8'h69});
    table_q.push_back('{3, 1, 60,  50, 0, 1, 2, 128'h0, 8'hff});
    // mixed widths, widening shapes
    table_q.push_back('{0, 0, 24,  2, 0, 1, 2, {8{16'h3c3c}}, 8'hff});
    table_q.push_back('{5, 1, 90,  0, 1, 1, 2, 128'h0, 8'h0f});
    table_q.push_back('{2, 1, 36,  3, 0, 0, 1, 128'h0, 8'hff});
endfunction

//--- test/tb_rvv_dispatch.sv
// Directed table against the dispatch top, then a burst under random stalls.
// Expected byte types come from a reference model of the byte-type rule.
`timescale 1ns/1ps

module tb_rvv_dispatch;

    localparam int unsigned TIMEOUT = 200;   // cycles allowed per wait
    localparam int unsigned CHECK_W = $bits(rvv_dispatch_pkg::dispatch_uop_t);

    typedef struct {
        int unsigned  uop_index;
        bit           vm;
        int unsigned  vl;
        int unsigned  vstart;
        int unsigned  vs1_eew;
        int unsigned  vs2_eew;
        int unsigned  vd_eew;
        logic [127:0] v0;
        logic [7:0]   ready_pat;
    } entry_t;

    logic                            clk;
    logic                            rst_n;
    logic                            in_valid;
    logic                            in_ready;
    rvv_dispatch_pkg::uop_info_t     in_uop;
    logic                            v0_wr_valid;
    rvv_arch_pkg::v0_t               v0_wr_data;
    logic                            out_valid;
    logic                            out_ready;
    rvv_dispatch_pkg::dispatch_uop_t out_uop;

    entry_t                          table_q[$];
    rvv_dispatch_pkg::dispatch_uop_t expect_q[$];
    rvv_arch_pkg::v0_t               v0_model;      // v0 the DUT uses at load
    logic [7:0]                      ready_pat;     // rotated once per cycle
    bit                              random_ready;
    int unsigned                     received;
    bit                              stalled;
    rvv_dispatch_pkg::dispatch_uop_t held_uop;

    `include "tb_rvv_dispatch_table.svh"

    rvv_dispatch_top #(
        .QUEUE_DEPTH (4)
    ) i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_uop      (in_uop),
        .v0_wr_valid (v0_wr_valid),
        .v0_wr_data  (v0_wr_data),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_uop     (out_uop)
    );

    always #20 clk = ~clk;

    always @(negedge clk) begin
        if (random_ready) begin
            out_ready = ($urandom % 3) != 0;   // stall about one cycle in three
        end else begin
            out_ready = ready_pat[0];
            ready_pat = {ready_pat[0], ready_pat[7:1]};
        end
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [CHECK_W-1:0] got,
                               input logic [CHECK_W-1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // element index = u * 16/w + b/w, then tail, prestart, mask
    function automatic rvv_dispatch_pkg::byte_type_vec_t ref_byte_types(
        input rvv_dispatch_pkg::uop_info_t info,
        input int unsigned                 eew,
        input rvv_arch_pkg::v0_t           v0
    );
        rvv_dispatch_pkg::byte_type_vec_t t;
        int unsigned                      w;
        int unsigned                      e;
        w = 1 << eew;
        for (int b = 0; b < 16; b++) begin
            e = info.uop_index * (16 / w) + b / w;
            if (e >= info.vl) begin
                t[b] = rvv_arch_pkg::TAIL;
            end else if (e < info.vstart) begin
                t[b] = rvv_arch_pkg::NOT_CHANGE;
            end else if (info.vm || v0[e]) begin
                t[b] = rvv_arch_pkg::BODY_ACTIVE;
            end else begin
                t[b] = rvv_arch_pkg::BODY_INACTIVE;
            end
        end
        return t;
    endfunction

    function automatic rvv_dispatch_pkg::uop_info_t make_uop(input entry_t e,
                                                              input logic [7:0] id);
        rvv_dispatch_pkg::uop_info_t u;
        u.uop_id    = id;
        u.uop_index = rvv_arch_pkg::uop_idx_t'(e.uop_index);
        u.vm        = e.vm;
        u.vl        = rvv_arch_pkg::vl_t'(e.vl);
        u.vstart    = rvv_arch_pkg::vstart_t'(e.vstart);
        u.vs1_eew   = rvv_arch_pkg::eew_e'(e.vs1_eew);
        u.vs2_eew   = rvv_arch_pkg::eew_e'(e.vs2_eew);
        u.vd_eew    = rvv_arch_pkg::eew_e'(e.vd_eew);
        return u;
    endfunction

    function automatic rvv_dispatch_pkg::dispatch_uop_t expected_for(
        input rvv_dispatch_pkg::uop_info_t u
    );
        rvv_dispatch_pkg::dispatch_uop_t d;
        d.uop_info      = u;
        d.byte_type.vs1 = ref_byte_types(u, int'(u.vs1_eew), v0_model);
        d.byte_type.vs2 = ref_byte_types(u, int'(u.vs2_eew), v0_model);
        d.byte_type.vd  = ref_byte_types(u, int'(u.vd_eew), v0_model);
        return d;
    endfunction

    task automatic compare_output();
        rvv_dispatch_pkg::dispatch_uop_t exp;
        if (expect_q.size() == 0) begin
            fail_run("output handshake happened with no uop outstanding");
        end else begin
            exp = expect_q.pop_front();
            check_value("out_uop.uop_info.uop_id", out_uop.uop_info.uop_id,
                        exp.uop_info.uop_id);
            check_value("out_uop.uop_info", out_uop.uop_info, exp.uop_info);
            check_value("out_uop.byte_type.vs1", out_uop.byte_type.vs1, exp.byte_type.vs1);
            check_value("out_uop.byte_type.vs2", out_uop.byte_type.vs2, exp.byte_type.vs2);
            check_value("out_uop.byte_type.vd", out_uop.byte_type.vd, exp.byte_type.vd);
            received++;
        end
    endtask

    // values seen here are the ones from just before the edge
    always @(posedge clk) begin
        if (rst_n) begin
            if (stalled) begin
                check_value("out_valid", out_valid, 1);
                check_value("out_uop", out_uop, held_uop);
            end
            if (out_valid && out_ready) begin
                compare_output();
            end
            stalled  = out_valid && !out_ready;
            held_uop = out_uop;
        end
    end

    task automatic write_v0(input rvv_arch_pkg::v0_t value);
        @(negedge clk);
        v0_wr_valid = 1'b1;
        v0_wr_data  = value;
        @(negedge clk);
        v0_wr_valid = 1'b0;
        v0_model    = value;
    endtask

    // leaves in_valid high, returns on the accepting edge
    task automatic push_uop(input rvv_dispatch_pkg::uop_info_t u);
        int unsigned n;
        bit          accepted;
        n = 0;
        @(negedge clk);
        in_valid = 1'b1;
        in_uop   = u;
        do begin
            @(posedge clk);
            accepted = in_ready;
            n++;
        end while (!accepted && n < TIMEOUT);
        if (!accepted) begin
            fail_run("input handshake never completed, in_ready stayed low");
        end else begin
            expect_q.push_back(expected_for(u));
        end
    endtask

    task automatic wait_out_empty();
        int unsigned n;
        n = 0;
        while (out_valid && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (out_valid) begin
            fail_run("output register never drained");
        end
    endtask

    task automatic wait_received(input int unsigned target);
        int unsigned n;
        n = 0;
        while (received < target && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (received < target) begin
            fail_run("output handshake never completed for an expected uop");
        end
    endtask

    initial begin
        entry_t e;
        void'($urandom(79450));
        clk          = 1'b0;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_uop       = '0;
        v0_wr_valid  = 1'b0;
        v0_wr_data   = '0;
        out_ready    = 1'b0;
        ready_pat    = '0;
        random_ready = 1'b0;
        received     = 0;
        stalled      = 1'b0;
        held_uop     = '0;
        v0_model     = '0;
        load_table();

        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("out_valid", out_valid, 0);
        check_value("in_ready", in_ready, 1);

        // one uop at a time, each under its own v0 and ready pattern
        foreach (table_q[i]) begin
            e = table_q[i];
            write_v0(e.v0);
            wait_out_empty();
            @(posedge clk);
            ready_pat = e.ready_pat;
            push_uop(make_uop(e, 8'(i)));
            @(negedge clk);
            in_valid = 1'b0;
            wait_received(i + 1);
        end

        // output held low fills output slot plus queue, then random drain
        write_v0({8{16'h5a3c}});
        wait_out_empty();
        @(posedge clk);
        ready_pat = '0;
        for (int i = 0; i < 5; i++) begin
            push_uop(make_uop(table_q[i], 8'(8'h80 + i)));
        end
        @(negedge clk);
        in_valid = 1'b0;
        check_value("in_ready", in_ready, 0);
        @(posedge clk);
        random_ready = 1'b1;
        for (int i = 5; i < table_q.size(); i++) begin
            push_uop(make_uop(table_q[i], 8'(8'h80 + i)));
        end
        @(negedge clk);
        in_valid = 1'b0;
        wait_received(2 * table_q.size());

        $display("** PASS **");
        $finish;
    end

endmodule

//--- compile.f
+incdir+test
design/rvv_arch_pkg.sv
design/rvv_dispatch_pkg.sv
design/rvv_uop_queue.sv
design/rvv_opr_byte_type.sv
design/rvv_dispatch_stage.sv
design/rvv_dispatch_top.sv
test/tb_rvv_dispatch.sv

//--- Bender.yml
package:
  name: rvv_dispatch

sources:
  - files:
      - design/rvv_arch_pkg.sv
      - design/rvv_dispatch_pkg.sv
      - design/rvv_uop_queue.sv
      - design/rvv_opr_byte_type.sv
      - design/rvv_dispatch_stage.sv
      - design/rvv_dispatch_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_rvv_dispatch.sv
